// ==== hw/ex_pkg.sv ====
package ex_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] t_reg_data;

    // Decoded micro-ops for the execute cluster
    typedef enum logic [4:0] {
        U_NOP,
        U_ADD,
        U_ADDW,
        U_SUB,
        U_SUBW,
        U_AND,
        U_XOR,
        U_OR,
        U_SLL,
        U_SLLW,
        U_SRL,
        U_SRLW,
        U_SRA,
        U_SRAW,
        U_SLT,
        U_SLTU,
        U_LUI,
        U_AUIPC,
        U_MUL,
        U_MULW
    } t_uop;

    // Width the result is sign-extended from
    typedef enum logic [1:0] {
        SZ_1B,
        SZ_2B,
        SZ_4B,
        SZ_8B
    } t_opsize;

    typedef struct packed {
        logic [4:0] rd;
        t_opsize    opsize;
    } t_dst;

    typedef struct packed {
        t_uop      uop;
        t_reg_data pc;
        t_dst      dst;
    } t_uinstr;

    typedef struct packed {
        logic [4:0] rd;
        t_reg_data  result;
    } t_wb;

    // Multiplier ops bypass the ALU
    function automatic logic is_mul_uop(t_uop uop);
        return uop inside {U_MUL, U_MULW};
    endfunction

endpackage

// ==== hw/ialu.sv ====
`timescale 1ns/1ps

module ialu
    import ex_pkg::*;
(
    input  logic      iss,
    input  t_uinstr   uinstr,
    input  t_reg_data src1val,
    input  t_reg_data src2val,

    output logic      resvld,
    output t_reg_data result
);

    t_reg_data              result_raw;
    logic [4:0]             shamt;
    logic signed [XLEN-1:0] src1_s;
    logic signed [XLEN-1:0] src2_s;
    logic signed [XLEN-1:0] src1_lo_s;
    t_reg_data              src1_lo_z;

    always_comb begin
        shamt     = src2val[4:0];
        src1_s    = src1val;
        src2_s    = src2val;
        // Low word widened for the W shifts
        src1_lo_s = {{(XLEN-32){src1val[31]}}, src1val[31:0]};
        src1_lo_z = {{(XLEN-32){1'b0}}, src1val[31:0]};
    end

    always_comb begin
        result_raw = '0;
        resvld     = iss;
        unique case (uinstr.uop)
            U_ADD:   result_raw = src1val + src2val;
            U_ADDW:  result_raw = src1val + src2val;
            U_SUB:   result_raw = src1val - src2val;
            U_SUBW:  result_raw = src1val - src2val;
            U_AND:   result_raw = src1val & src2val;
            U_XOR:   result_raw = src1val ^ src2val;
            U_OR:    result_raw = src1val | src2val;
            U_SLL:   result_raw = src1val << shamt;
            U_SLLW:  result_raw = src1_lo_z << shamt;
            U_SRL:   result_raw = src1val >> shamt;
            U_SRLW:  result_raw = src1_lo_z >> shamt;
            U_SRA:   result_raw = src1_s >>> shamt;
            U_SRAW:  result_raw = src1_lo_s >>> shamt;
            U_SLT:   result_raw = (src1_s < src2_s) ? t_reg_data'(1) : t_reg_data'(0);
            U_SLTU:  result_raw = (src1val < src2val) ? t_reg_data'(1) : t_reg_data'(0);
            U_LUI:   result_raw = src2val;
            U_AUIPC: result_raw = src2val + uinstr.pc;
            default: begin
                // NOP and multiplier ops produce nothing here
                resvld     = 1'b0;
                result_raw = '0;
            end
        endcase
    end

    // Sign extension by destination size
    always_comb begin
        unique case (uinstr.dst.opsize)
            SZ_1B:   result = {{(XLEN-8){result_raw[7]}}, result_raw[7:0]};
            SZ_2B:   result = {{(XLEN-16){result_raw[15]}}, result_raw[15:0]};
            SZ_4B:   result = {{(XLEN-32){result_raw[31]}}, result_raw[31:0]};
            SZ_8B:   result = result_raw;
            default: result = result_raw;
        endcase
    end

endmodule

// ==== hw/mul_ctl.sv ====
`timescale 1ns/1ps

module mul_ctl
    import ex_pkg::*;
#(
    parameter int MUL_BPC = 2
) (
    input  logic clk,
    input  logic rst_n,

    input  logic mul_start,
    input  logic last,

    output logic load,
    output logic step,
    output logic busy,
    output logic mul_done
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } t_state;

    t_state state;
    t_state state_nxt;

    // Iteration count must come out whole
    if (XLEN % MUL_BPC != 0) begin : g_bpc_check
        $error("MUL_BPC does not divide XLEN");
    end

    always_comb begin
        state_nxt = state;
        unique case (state)
            IDLE:    if (mul_start) state_nxt = RUN;
            RUN:     if (last) state_nxt = IDLE;
            DONE:    state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Operands are captured in the issue cycle itself
    assign load     = (state == IDLE) && mul_start;
    assign step     = (state == RUN);
    assign busy     = (state == RUN);
    assign mul_done = (state == RUN) && last;

endmodule

// ==== hw/mul_count.sv ====
`timescale 1ns/1ps

module mul_count
    import ex_pkg::*;
#(
    parameter int MUL_BPC = 2
) (
    input  logic clk,
    input  logic rst_n,
    input  logic load,
    input  logic step,
    output logic last
);

    localparam int ITER  = XLEN / MUL_BPC;
    localparam int CNT_W = (ITER > 1) ? $clog2(ITER) : 1;

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (load) begin
            count <= CNT_W'(ITER - 1);
        end else if (step && (count != '0)) begin
            count <= count - 1'b1;
        end
    end

    assign last = step && (count == '0);

endmodule

// ==== hw/mul_datapath.sv ====
`timescale 1ns/1ps

module mul_datapath
    import ex_pkg::*;
#(
    parameter int MUL_BPC = 2
) (
    input  logic      clk,
    input  logic      rst_n,

    input  logic      load,
    input  logic      step,
    input  logic      mul_done,

    input  t_uinstr   uinstr,
    input  t_reg_data src1val,
    input  t_reg_data src2val,

    output logic      mul_vld,
    output t_wb       mul_wb
);

    t_reg_data  mcand;
    t_reg_data  mplier;
    t_reg_data  acc;
    t_reg_data  partial;
    t_reg_data  acc_nxt;
    logic [4:0] rd;
    logic       is_mulw;

    // Multiplicand times the low MUL_BPC multiplier bits
    always_comb begin
        partial = '0;
        for (int i = 0; i < MUL_BPC; i++) begin
            if (mplier[i]) begin
                partial = partial + (mcand << i);
            end
        end
        acc_nxt = acc + partial;
    end

    always_ff @(posedge clk) begin
        if (load) begin
            mcand  <= src1val;
            mplier <= src2val;
        end else if (step) begin
            mcand  <= mcand << MUL_BPC;
            mplier <= mplier >> MUL_BPC;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc     <= '0;
            rd      <= '0;
            is_mulw <= 1'b0;
        end else if (load) begin
            acc     <= '0;
            rd      <= uinstr.dst.rd;
            is_mulw <= (uinstr.uop == U_MULW);
        end else if (step) begin
            acc     <= acc_nxt;
        end
    end

    // Final step is folded in so the product is ready with mul_done
    assign mul_vld   = mul_done;
    assign mul_wb.rd = rd;
    assign mul_wb.result = is_mulw ? {{(XLEN-32){acc_nxt[31]}}, acc_nxt[31:0]} : acc_nxt;

endmodule

// ==== hw/ex_writeback.sv ====
`timescale 1ns/1ps

module ex_writeback
    import ex_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  logic       alu_vld,
    input  logic [4:0] alu_rd,
    input  t_reg_data  alu_result,

    input  logic       mul_vld,
    input  t_wb        mul_wb,

    output logic       wb_vld,
    output t_wb        wb
);

    t_wb wb_nxt;

    // ALU first, though busy keeps the two apart
    always_comb begin
        wb_nxt = wb;
        if (alu_vld) begin
            wb_nxt.rd     = alu_rd;
            wb_nxt.result = alu_result;
        end else if (mul_vld) begin
            wb_nxt = mul_wb;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_vld <= 1'b0;
            wb     <= '0;
        end else begin
            wb_vld <= alu_vld || mul_vld;
            wb     <= wb_nxt;
        end
    end

endmodule

// ==== hw/ex_unit.sv ====
`timescale 1ns/1ps

module ex_unit
    import ex_pkg::*;
#(
    parameter int MUL_BPC = 2
) (
    input  logic      clk,
    input  logic      rst_n,

    input  logic      iss,
    input  t_uinstr   uinstr,
    input  t_reg_data src1val,
    input  t_reg_data src2val,

    output logic      busy,
    output logic      wb_vld,
    output t_wb       wb
);

    logic      alu_iss;
    logic      alu_vld;
    t_reg_data alu_result;
    logic      mul_start;
    logic      mul_load;
    logic      mul_step;
    logic      mul_last;
    logic      mul_done;
    logic      mul_vld;
    t_wb       mul_wb;

    // Issue steering
    assign mul_start = iss && is_mul_uop(uinstr.uop);
    assign alu_iss   = iss && !is_mul_uop(uinstr.uop);

    ialu u_ialu (
        .iss     (alu_iss),
        .uinstr  (uinstr),
        .src1val (src1val),
        .src2val (src2val),
        .resvld  (alu_vld),
        .result  (alu_result)
    );

    mul_ctl #(.MUL_BPC(MUL_BPC)) u_mul_ctl (
        .clk       (clk),
        .rst_n     (rst_n),
        .mul_start (mul_start),
        .last      (mul_last),
        .load      (mul_load),
        .step      (mul_step),
        .busy      (busy),
        .mul_done  (mul_done)
    );

    mul_count #(.MUL_BPC(MUL_BPC)) u_mul_count (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (mul_load),
        .step  (mul_step),
        .last  (mul_last)
    );

    mul_datapath #(.MUL_BPC(MUL_BPC)) u_mul_datapath (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (mul_load),
        .step     (mul_step),
        .mul_done (mul_done),
        .uinstr   (uinstr),
        .src1val  (src1val),
        .src2val  (src2val),
        .mul_vld  (mul_vld),
        .mul_wb   (mul_wb)
    );

    ex_writeback u_ex_writeback (
        .clk        (clk),
        .rst_n      (rst_n),
        .alu_vld    (alu_vld),
        .alu_rd     (uinstr.dst.rd),
        .alu_result (alu_result),
        .mul_vld    (mul_vld),
        .mul_wb     (mul_wb),
        .wb_vld     (wb_vld),
        .wb         (wb)
    );

endmodule

// ==== dv/ex_unit_assert.sv ====
`timescale 1ns/1ps

module ex_unit_assert (
    input logic clk,
    input logic rst_n,
    input logic iss,
    input logic busy,
    input logic wb_vld,
    input logic mul_vld
);

    int err_count = 0;

    // Issuer holds off while the multiplier runs
    a_no_iss_busy: assert property (@(posedge clk) disable iff (!rst_n) !(iss && busy))
        else begin
            $error("iss high while busy");
            err_count++;
        end

    // Multiplier idle out of reset
    a_idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !busy)
        else begin
            $error("busy high right after reset");
            err_count++;
        end

    // One writeback pulse per product
    a_mul_single_wb: assert property (
        @(posedge clk) disable iff (!rst_n) mul_vld |=> (wb_vld && !mul_vld))
        else begin
            $error("multiplier result not a single writeback pulse");
            err_count++;
        end

endmodule

bind ex_unit ex_unit_assert u_ex_unit_assert (
    .clk     (clk),
    .rst_n   (rst_n),
    .iss     (iss),
    .busy    (busy),
    .wb_vld  (wb_vld),
    .mul_vld (mul_vld)
);

// ==== dv/ex_unit_tb.sv ====
`timescale 1ns/1ps

module ex_unit_tb
    import ex_pkg::*;
();

    localparam int MUL_BPC = 2;
    localparam int ITER    = XLEN / MUL_BPC;

    logic        clk;
    logic        rst_n;
    logic        iss;
    t_uinstr     uinstr;
    t_reg_data   src1val;
    t_reg_data   src2val;
    logic        busy;
    logic        wb_vld;
    t_wb         wb;
    logic [31:0] lfsr = 32'hf72b_bb8d;
    t_wb         exp_q[$];
    int          due_q[$];
    int          cyc = 0;
    int          errors = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          assert_seen = 0;

    ex_unit #(.MUL_BPC(MUL_BPC)) uut (
        .clk(clk), .rst_n(rst_n), .iss(iss), .uinstr(uinstr),
        .src1val(src1val), .src2val(src2val),
        .busy(busy), .wb_vld(wb_vld), .wb(wb)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Galois LFSR, one step per bit taken
    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[62:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic t_uop rand_alu_uop();
        return t_uop'(rand_bits(5) % 17 + 1);
    endfunction

    // Expected writeback for one instruction
    function automatic t_wb ref_wb(t_uop uop, t_reg_data a, t_reg_data b,
                                   t_reg_data pc, t_dst dst);
        t_reg_data          raw;
        logic signed [63:0] sx;
        logic [4:0]         sh;
        int                 w;
        t_wb                res;
        sh = b[4:0];
        sx = (uop == U_SRAW) ? {{32{a[31]}}, a[31:0]} : a;
        case (uop)
            U_ADD, U_ADDW: raw = a + b;
            U_SUB, U_SUBW: raw = a - b;
            U_AND:         raw = a & b;
            U_XOR:         raw = a ^ b;
            U_OR:          raw = a | b;
            U_SLL:         raw = a << sh;
            U_SLLW:        raw = {32'h0, a[31:0]} << sh;
            U_SRL:         raw = a >> sh;
            U_SRLW:        raw = {32'h0, a[31:0]} >> sh;
            U_SRA, U_SRAW: raw = sx >>> sh;
            U_SLT:         raw = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            U_SLTU:        raw = (a < b) ? 64'd1 : 64'd0;
            U_LUI:         raw = b;
            U_AUIPC:       raw = b + pc;
            U_MUL, U_MULW: raw = a * b;
            default:       raw = '0;
        endcase
        // Sign extend from the destination width
        w  = is_mul_uop(uop) ? ((uop == U_MULW) ? 32 : 64) : (8 << dst.opsize);
        sx = raw << (64 - w);
        sx = sx >>> (64 - w);
        res.rd     = dst.rd;
        res.result = sx;
        return res;
    endfunction

    task automatic issue(t_uop uop, t_reg_data a, t_reg_data b, t_opsize sz);
        t_uinstr ui;
        ui.uop        = uop;
        ui.pc         = rand_bits(64);
        ui.dst.rd     = rand_bits(5);
        ui.dst.opsize = sz;
        @(posedge clk);
        iss     <= 1'b1;
        uinstr  <= ui;
        src1val <= a;
        src2val <= b;
        if (uop != U_NOP) begin
            exp_q.push_back(ref_wb(uop, a, b, ui.pc, ui.dst));
            due_q.push_back(cyc + (is_mul_uop(uop) ? ITER + 2 : 2));
        end
    endtask

    task automatic go_idle();
        @(posedge clk);
        iss <= 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        go_idle();
        while (exp_q.size() != 0 && n < 2 * ITER + 10) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d results never written back", exp_q.size());
            errors++;
            exp_q.delete();
            due_q.delete();
        end
    endtask

    // Counts busy cycles of one multiply
    task automatic check_busy_len();
        int n;
        n = 0;
        go_idle();
        for (int k = 0; k < ITER + 8; k++) begin
            @(negedge clk);
            if (busy) begin
                n++;
            end else if (n > 0) begin
                break;
            end
        end
        if (n != ITER) begin
            $display("** Error at %0t: busy high %0d cycles, expected %0d", $time, n, ITER);
            errors++;
        end
    endtask

    // Returns just before the edge where busy falls
    task automatic wait_busy_end();
        int n;
        n = 0;
        go_idle();
        for (int k = 0; k < ITER + 8 && n < ITER; k++) begin
            @(negedge clk);
            if (busy) n++;
        end
        if (n < ITER) begin
            $display("Timeout: multiplier did not stay busy for %0d cycles", ITER);
            errors++;
        end
    endtask

    task automatic end_test(string name, int err_before);
        // Protocol assertion failures count against the test that ran
        errors      += uut.u_ex_unit_assert.err_count - assert_seen;
        assert_seen  = uut.u_ex_unit_assert.err_count;
        if (errors == err_before) begin
            pass_cnt++;
            $display("[pass] %s", name);
        end else begin
            fail_cnt++;
            $display("[fail] %s, %0d errors", name, errors - err_before);
        end
    endtask

    // Writeback compare against the expected queue
    always @(negedge clk) begin
        t_wb exp;
        int  due;
        cyc = cyc + 1;
        if (wb_vld) begin
            if (exp_q.size() == 0) begin
                $display("Writeback at %0t with no instruction pending", $time);
                errors++;
            end else begin
                exp = exp_q.pop_front();
                due = due_q.pop_front();
                if (wb !== exp) begin
                    $display("** Error at %0t: rd %0d result %h, expected rd %0d result %h",
                             $time, wb.rd, wb.result, exp.rd, exp.result);
                    errors++;
                end
                if (cyc != due) begin
                    $display("** Error at %0t: writeback %0d cycles late", $time, cyc - due);
                    errors++;
                end
            end
        end
    end

    initial begin
        t_reg_data corner [8];
        t_reg_data a;
        t_reg_data b;
        int        e;
        corner = '{64'h0, 64'hffff_ffff_ffff_ffff, 64'h1, 64'd31, 64'h8000_0000_0000_0000,
                   64'h7fff_ffff_ffff_ffff, 64'h0000_0000_8000_0000, 64'h0123_4567_89ab_cdef};
        rst_n   = 1'b0;
        iss     = 1'b0;
        uinstr  = '0;
        src1val = '0;
        src2val = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        e = errors;
        @(negedge clk);
        if (busy !== 1'b0 || wb_vld !== 1'b0 || wb !== '0) begin
            $display("** Error at %0t: outputs not cleared after reset", $time);
            errors++;
        end
        end_test("reset", e);

        e = errors;
        for (int u = 1; u <= 17; u++)
            for (int s = 0; s < 4; s++)
                for (int i = 0; i < 8; i++)
                    for (int j = 0; j < 8; j++)
                        issue(t_uop'(5'(u)), corner[i], corner[j], t_opsize'(2'(s)));
        drain();
        end_test("alu sweep", e);

        e = errors;
        repeat (200) issue(rand_alu_uop(), rand_bits(64), rand_bits(64), t_opsize'(rand_bits(2)));
        drain();
        end_test("alu random back to back", e);

        // Directed pairs first, then random operands
        e = errors;
        for (int i = 0; i < 32; i++) begin
            a = (i < 16) ? corner[i / 2] : rand_bits(64);
            b = (i < 16) ? corner[(i / 2 + 1) % 8] : rand_bits(64);
            issue(i[0] ? U_MULW : U_MUL, a, b, SZ_8B);
            check_busy_len();
            drain();
        end
        end_test("multiplier", e);

        e = errors;
        for (int i = 0; i < 60; i++) begin
            a = rand_bits(64);
            b = rand_bits(64);
            if (rand_bits(2) == 0) begin
                issue(rand_bits(1) ? U_MULW : U_MUL, a, b, SZ_8B);
                wait_busy_end();
            end else begin
                issue(rand_alu_uop(), a, b, t_opsize'(rand_bits(2)));
            end
        end
        drain();
        end_test("mixed stream", e);

        e = errors;
        issue(U_NOP, rand_bits(64), rand_bits(64), SZ_8B);
        go_idle();
        repeat (10) begin
            @(negedge clk);
            if (wb_vld) begin
                $display("** Error at %0t: writeback after NOP", $time);
                errors++;
            end
        end
        end_test("nop", e);

        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
hw/ex_pkg.sv
hw/ialu.sv
hw/mul_ctl.sv
hw/mul_count.sv
hw/mul_datapath.sv
hw/ex_writeback.sv
hw/ex_unit.sv
dv/ex_unit_assert.sv
dv/ex_unit_tb.sv
